/* src/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ========================================
// Rename map sizes
// ========================================

// Architectural registers named by the instruction set
`define NUM_AREGS 16
// Physical registers behind the rename map
`define NUM_PREGS 64
`define NUM_CHECK 16  // Branch checkpoint slots in the ring

`endif

/* src/rename_pkg.sv */
`include "rename_defines.svh"

package rename_pkg;

   // ========================================
   // Field widths derived from the sizes
   // ========================================
   localparam int AREG_W = $clog2(`NUM_AREGS);       // 4 bits for 16 registers
   localparam int PREG_W = $clog2(`NUM_PREGS);       // 6 bits for 64 registers
   localparam int CHK_W  = $clog2(`NUM_CHECK);       // Slot index width
   localparam int CNT_W  = $clog2(`NUM_CHECK + 1);   // Count must reach NUM_CHECK itself

   typedef logic [AREG_W-1:0] areg_t;     // Architectural register number
   typedef logic [PREG_W-1:0] preg_t;     // Physical register number
   typedef logic [CHK_W-1:0]  chk_id_t;   // Checkpoint slot index
   typedef logic [CNT_W-1:0]  chk_cnt_t;  // Number of live checkpoints

   // Whole map as one packed vector
   // Field i holds the physical register of architectural register i
   typedef logic [`NUM_AREGS-1:0][PREG_W-1:0] map_vec_t;

endpackage

/* src/rename_op_pkg.sv */
package rename_op_pkg;

   // ========================================
   // Rename command opcodes
   // ========================================
   typedef enum logic [2:0] {
      RN_NOP     = 3'd0,  // Idle cycle
      RN_MAP     = 3'd1,  // Point arch_reg at new_preg
      RN_SAVE    = 3'd2,  // Snapshot the live map into the next checkpoint
      RN_RESTORE = 3'd3,  // Reload the map from restore_id and drop younger slots
      RN_FREE    = 3'd4   // Retire the oldest checkpoint
   } rn_op_e;

   // Encodings 5 to 7 are unused and decode as a no-op

endpackage

/* src/checkpoint_ram.sv */
`include "rename_defines.svh"

module checkpoint_ram
   import rename_pkg::*;
(
   input  logic     clka,       // Single clock for the write port
   input  logic     ram_we,     // Write strobe for a checkpoint save
   input  chk_id_t  ram_waddr,  // Slot being written
   input  map_vec_t ram_wdata,  // Full map to store
   input  chk_id_t  ram_raddr,  // Slot being read for a restore
   output map_vec_t ram_rdata   // Stored map of the read slot
);

   // ========================================
   // Storage array
   // ========================================

   // One full map per checkpoint slot
   // Small and wide so it maps onto distributed LUT memory
   map_vec_t mem [0:`NUM_CHECK-1];

   // Clear the array at load time since LUT RAM has no reset
   initial begin
      for (int n = 0; n < `NUM_CHECK; n++) begin
         mem[n] = '0;
      end
   end

   // ========================================
   // Write port
   // ========================================

   // A save always writes every field of the map
   always_ff @(posedge clka) begin
      if (ram_we) begin
         mem[ram_waddr] <= ram_wdata;  // Lands at the edge that samples the save
      end
   end

   // ========================================
   // Read port
   // ========================================

   // Asynchronous read so a restore completes within the same cycle
   // A write to the same slot at this edge is not yet visible here
   assign ram_rdata = mem[ram_raddr];

endmodule

/* src/map_table.sv */
`include "rename_defines.svh"

module map_table
   import rename_pkg::*;
(
   input  logic     clka,
   input  logic     arst_n,       // Asynchronous active low reset
   input  logic     map_we,       // Rename one register
   input  areg_t    arch_reg,     // Register being renamed
   input  preg_t    new_preg,     // Its new physical register
   input  logic     restore_en,   // Load the whole map from a checkpoint
   input  map_vec_t restore_map,  // Checkpoint contents to load
   input  areg_t    lookup_areg,  // Register to look up
   output preg_t    lookup_preg,  // Current mapping of lookup_areg
   output map_vec_t map_vec       // Whole live map for checkpoint saves
);

   // ========================================
   // Live map registers
   // ========================================

   map_vec_t map_q;  // Field i is the mapping of architectural register i

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         // Identity map at reset
         for (int i = 0; i < `NUM_AREGS; i++) begin
            map_q[i] <= preg_t'(i);  // Register i starts in physical register i
         end
      end else if (restore_en) begin
         // Branch recovery replaces every field at once
         map_q <= restore_map;
      end else if (map_we) begin
         map_q[arch_reg] <= new_preg;  // Only the named field changes
      end
   end

   // Restore and rename are never raised together by the controller
   // so the priority above only matters for clarity

   // ========================================
   // Outputs
   // ========================================

   // Lookup mux reads the registered map directly
   assign lookup_preg = map_q[lookup_areg];

   // The map leaves as one vector to feed the checkpoint RAM
   assign map_vec = map_q;

endmodule

/* src/rename_ctrl.sv */
`include "rename_defines.svh"

module rename_ctrl
   import rename_pkg::*;
   import rename_op_pkg::*;
(
   input  logic     clka,
   input  logic     arst_n,      // Asynchronous active low reset
   input  rn_op_e   op,          // Command for this cycle
   input  chk_id_t  restore_id,  // Slot to restore from
   output logic     map_we,      // Accepted rename
   output logic     restore_en,  // Accepted restore
   output logic     ram_we,      // Accepted save
   output chk_id_t  ram_waddr,   // Slot the save writes
   output chk_id_t  chk_id,      // Slot the next save will use
   output chk_cnt_t chk_count,   // Live checkpoints in the ring
   output logic     chk_full,    // No slot left for a save
   output logic     chk_empty    // Nothing to free
);

   // ========================================
   // Ring state
   // ========================================

   chk_id_t  head_q;   // Next slot to be written
   chk_id_t  tail_q;   // Oldest live slot
   chk_cnt_t count_q;  // Number of live slots between tail and head
   logic     full_q;   // Registered copy of count == NUM_CHECK
   logic     empty_q;  // Registered copy of count == 0

   chk_id_t  head_nxt;
   chk_id_t  tail_nxt;
   chk_cnt_t count_nxt;

   // Distance of the requested slot from the oldest one
   chk_id_t  restore_age;
   logic     restore_live;  // Requested slot holds a live checkpoint

   // Accepted command strobes
   logic     save_ok;
   logic     free_ok;
   logic     restore_ok;

   // ========================================
   // Acceptance
   // ========================================

   // Wraps modulo the ring size because chk_id_t is exactly the index width
   assign restore_age  = restore_id - tail_q;
   // Zero extended age compared against the count
   assign restore_live = chk_cnt_t'(restore_age) < count_q;

   assign save_ok    = (op == RN_SAVE) && !full_q;     // Back-pressure on a full ring
   assign free_ok    = (op == RN_FREE) && !empty_q;    // Nothing to retire when empty
   assign restore_ok = (op == RN_RESTORE) && restore_live;

   // ========================================
   // Next ring state
   // ========================================

   always_comb begin
      head_nxt  = head_q;
      tail_nxt  = tail_q;
      count_nxt = count_q;
      case (op)
         RN_SAVE: begin
            if (save_ok) begin
               head_nxt  = head_q + chk_id_t'(1);    // Advance past the slot written
               count_nxt = count_q + chk_cnt_t'(1);
            end
         end
         RN_RESTORE: begin
            if (restore_ok) begin
               // Restored slot becomes the youngest live one
               head_nxt  = restore_id + chk_id_t'(1);
               count_nxt = chk_cnt_t'(restore_age) + chk_cnt_t'(1);
            end
         end
         RN_FREE: begin
            if (free_ok) begin
               tail_nxt  = tail_q + chk_id_t'(1);    // Oldest branch has retired
               count_nxt = count_q - chk_cnt_t'(1);
            end
         end
         default: begin
            // Renames and idle cycles leave the ring alone
         end
      endcase
   end

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
         full_q  <= 1'b0;
         empty_q <= 1'b1;  // Ring starts with no checkpoints
      end else begin
         head_q  <= head_nxt;
         tail_q  <= tail_nxt;
         count_q <= count_nxt;
         // Status flags follow the new count so they come from flops
         full_q  <= (count_nxt == chk_cnt_t'(`NUM_CHECK));
         empty_q <= (count_nxt == '0);
      end
   end

   // ========================================
   // Strobes and status
   // ========================================

   assign map_we     = (op == RN_MAP);  // Renames are always accepted
   assign restore_en = restore_ok;
   assign ram_we     = save_ok;
   assign ram_waddr  = head_q;          // Saves always fill the head slot

   assign chk_id    = head_q;
   assign chk_count = count_q;
   assign chk_full  = full_q;
   assign chk_empty = empty_q;

endmodule

/* src/rename_unit.sv */
module rename_unit
   import rename_pkg::*;
   import rename_op_pkg::*;
(
   input  logic     clka,
   input  logic     arst_n,       // Asynchronous active low reset
   input  rn_op_e   op,           // Command sampled at the rising edge
   input  areg_t    arch_reg,     // Register renamed by RN_MAP
   input  preg_t    new_preg,     // New physical register for RN_MAP
   input  chk_id_t  restore_id,   // Slot used by RN_RESTORE
   input  areg_t    lookup_areg,  // Register to look up
   output preg_t    lookup_preg,  // Live mapping of lookup_areg
   output chk_id_t  chk_id,       // Slot the next save will use
   output chk_cnt_t chk_count,    // Live checkpoints
   output logic     chk_full,     // Saves are refused while set
   output logic     chk_empty     // Frees are refused while set
);

   // ========================================
   // Internal connections
   // ========================================

   logic     map_we;      // Controller to map table
   logic     restore_en;  // Controller to map table
   logic     ram_we;      // Controller to checkpoint RAM
   chk_id_t  ram_waddr;   // Controller to checkpoint RAM
   map_vec_t map_vec;     // Live map into the RAM write port
   map_vec_t ram_rdata;   // Stored map back into the map table

   // ========================================
   // Command decode and checkpoint ring
   // ========================================

   rename_ctrl rename_ctrl_inst (
      .clka       (clka),
      .arst_n     (arst_n),
      .op         (op),
      .restore_id (restore_id),
      .map_we     (map_we),
      .restore_en (restore_en),
      .ram_we     (ram_we),
      .ram_waddr  (ram_waddr),
      .chk_id     (chk_id),
      .chk_count  (chk_count),
      .chk_full   (chk_full),
      .chk_empty  (chk_empty)
   );

   // ========================================
   // Live map
   // ========================================

   map_table map_table_inst (
      .clka        (clka),
      .arst_n      (arst_n),
      .map_we      (map_we),
      .arch_reg    (arch_reg),
      .new_preg    (new_preg),
      .restore_en  (restore_en),
      .restore_map (ram_rdata),    // Restore data comes straight from the RAM read
      .lookup_areg (lookup_areg),
      .lookup_preg (lookup_preg),
      .map_vec     (map_vec)
   );

   // ========================================
   // Checkpoint storage
   // ========================================

   checkpoint_ram checkpoint_ram_inst (
      .clka      (clka),
      .ram_we    (ram_we),
      .ram_waddr (ram_waddr),
      .ram_wdata (map_vec),
      .ram_raddr (restore_id),  // Read address needs no decode
      .ram_rdata (ram_rdata)
   );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
   parameter int PERIOD = 20  // Full clock period in time units
) (
   output logic clka
);

   // ========================================
   // Free running clock
   // ========================================

   initial begin
      clka = 1'b0;  // Known level before the first edge
   end

   // Half a period high and half a period low
   always #(PERIOD / 2) clka = ~clka;

endmodule

/* sim/rename_unit_tb.sv */
`include "rename_defines.svh"

module rename_unit_tb
   import rename_pkg::*;
   import rename_op_pkg::*;
();

   localparam int RESET_CYCLES  = 10;     // Cycles with arst_n held low
   localparam int RESET_TIMEOUT = 50;     // Cycles allowed for the outputs to settle
   localparam int RANDOM_CYCLES = 600;    // Length of the random phase
   localparam int SEED          = 23729;

   // One table row holds the command inputs and the outputs expected one cycle later
   typedef struct packed {
      rn_op_e   op;
      areg_t    arch_reg;
      preg_t    new_preg;
      chk_id_t  restore_id;
      areg_t    lookup_areg;
      preg_t    exp_lookup;
      chk_cnt_t exp_count;
      logic     exp_full;
   } row_t;

   logic     clka;
   logic     arst_n;
   rn_op_e   op;
   areg_t    arch_reg;
   preg_t    new_preg;
   chk_id_t  restore_id;
   areg_t    lookup_areg;
   preg_t    lookup_preg;
   chk_id_t  chk_id;
   chk_cnt_t chk_count;
   logic     chk_full;
   logic     chk_empty;

   row_t rows [$];  // Directed stimulus table

   // Reference model of the live map and the checkpoint ring
   preg_t ref_map  [0:`NUM_AREGS-1];
   preg_t ref_ckpt [0:`NUM_CHECK-1][0:`NUM_AREGS-1];
   int    ref_head;
   int    ref_tail;
   int    ref_count;

   // ========================================
   // Clock and DUT
   // ========================================

   tb_clock_gen #(.PERIOD(20)) tb_clock_gen_inst (.clka(clka));

   rename_unit rename_unit_inst (
      .clka        (clka),
      .arst_n      (arst_n),
      .op          (op),
      .arch_reg    (arch_reg),
      .new_preg    (new_preg),
      .restore_id  (restore_id),
      .lookup_areg (lookup_areg),
      .lookup_preg (lookup_preg),
      .chk_id      (chk_id),
      .chk_count   (chk_count),
      .chk_full    (chk_full),
      .chk_empty   (chk_empty)
   );

   // ========================================
   // Helpers
   // ========================================

   // Xorshift32 step for the random phase
   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic add_row(input rn_op_e o, input int a, input int p, input int rid,
                          input int la, input int el, input int ec, input int ef);
      row_t r;
      r.op          = o;
      r.arch_reg    = areg_t'(a);
      r.new_preg    = preg_t'(p);
      r.restore_id  = chk_id_t'(rid);
      r.lookup_areg = areg_t'(la);
      r.exp_lookup  = preg_t'(el);
      r.exp_count   = chk_cnt_t'(ec);
      r.exp_full    = (ef != 0);
      rows.push_back(r);
   endtask

   // Puts the model in its reset state with an identity map and an empty ring
   task automatic model_reset();
      for (int i = 0; i < `NUM_AREGS; i++) begin
         ref_map[i] = preg_t'(i);
      end
      for (int s = 0; s < `NUM_CHECK; s++) begin
         for (int i = 0; i < `NUM_AREGS; i++) begin
            ref_ckpt[s][i] = '0;  // RAM starts cleared
         end
      end
      ref_head  = 0;
      ref_tail  = 0;
      ref_count = 0;
   endtask

   // Applies one command to the model following the command rules
   task automatic model_step(input row_t r);
      int age;
      age = (int'(r.restore_id) - ref_tail + `NUM_CHECK) % `NUM_CHECK;  // Slots past the tail
      case (r.op)
         RN_MAP: ref_map[r.arch_reg] = r.new_preg;
         RN_SAVE: begin
            if (ref_count < `NUM_CHECK) begin
               for (int i = 0; i < `NUM_AREGS; i++) begin
                  ref_ckpt[ref_head][i] = ref_map[i];
               end
               ref_head  = (ref_head + 1) % `NUM_CHECK;
               ref_count = ref_count + 1;
            end
         end
         RN_RESTORE: begin
            if (age < ref_count) begin  // Dead ids are ignored
               for (int i = 0; i < `NUM_AREGS; i++) begin
                  ref_map[i] = ref_ckpt[r.restore_id][i];
               end
               ref_head  = (int'(r.restore_id) + 1) % `NUM_CHECK;
               ref_count = age + 1;  // Restored slot is now the youngest
            end
         end
         RN_FREE: begin
            if (ref_count > 0) begin
               ref_tail  = (ref_tail + 1) % `NUM_CHECK;
               ref_count = ref_count - 1;
            end
         end
         default: begin
         end
      endcase
   endtask

   // Entered 2 units after an edge and returns 2 units after the next one
   task automatic apply_row(input row_t r);
      op          = r.op;
      arch_reg    = r.arch_reg;
      new_preg    = r.new_preg;
      restore_id  = r.restore_id;
      lookup_areg = r.lookup_areg;
      @(posedge clka);
      #1;  // Outputs have settled after the sampling edge
      check_value("lookup_preg", 32'(lookup_preg), 32'(r.exp_lookup));
      check_value("chk_count", 32'(chk_count), 32'(r.exp_count));
      check_value("chk_full", 32'(chk_full), 32'(r.exp_full));
      check_value("chk_empty", 32'(chk_empty), 32'(r.exp_count == '0));
      check_value("chk_id", 32'(chk_id), 32'(ref_head));
      #1;
   endtask

   // Polls the status outputs until the ring reads as freshly reset
   task automatic wait_reset_release();
      int  cycles;
      logic ready;
      cycles = 0;
      ready  = 1'b0;
      while (!ready) begin
         @(posedge clka);
         #1;
         if (chk_empty === 1'b1 && chk_full === 1'b0 && chk_count === '0) begin
            ready = 1'b1;
         end else begin
            cycles = cycles + 1;
            if (cycles >= RESET_TIMEOUT) begin
               $display("Timed out waiting for the DUT to leave reset");
               $display("Test failed");
               $fatal(1);
            end
         end
      end
      #1;  // Line up with the input drive point
   endtask

   // ========================================
   // Directed table
   // ========================================

   task automatic build_table();
      // Every register maps to itself after reset
      for (int i = 0; i < `NUM_AREGS; i++) begin
         add_row(RN_NOP, 0, 0, 0, i, i, 0, 0);
      end
      add_row(RN_MAP, 3, 40, 0, 3, 40, 0, 0);  // Only register 3 moves
      add_row(RN_NOP, 0, 0, 0, 2, 2, 0, 0);
      add_row(RN_NOP, 0, 0, 0, 4, 4, 0, 0);
      // Two checkpoints with renames in between
      add_row(RN_SAVE, 0, 0, 0, 3, 40, 1, 0);
      add_row(RN_MAP, 5, 50, 0, 5, 50, 1, 0);
      add_row(RN_SAVE, 0, 0, 0, 5, 50, 2, 0);
      add_row(RN_MAP, 3, 33, 0, 3, 33, 2, 0);
      add_row(RN_MAP, 7, 17, 0, 7, 17, 2, 0);
      add_row(RN_RESTORE, 0, 0, 0, 5, 5, 1, 0);  // Back to slot 0 and slot 1 is dropped
      add_row(RN_NOP, 0, 0, 0, 3, 40, 1, 0);
      add_row(RN_NOP, 0, 0, 0, 7, 7, 1, 0);
      add_row(RN_RESTORE, 0, 0, 1, 5, 5, 1, 0);  // Slot 1 is dead now
      add_row(RN_FREE, 0, 0, 0, 3, 40, 0, 0);
      add_row(RN_FREE, 0, 0, 0, 3, 40, 0, 0);    // Empty ring ignores the free
      add_row(RN_MAP, 3, 60, 0, 3, 60, 0, 0);
      add_row(RN_RESTORE, 0, 0, 1, 3, 60, 0, 0); // Nothing live to restore
      // Fill the ring starting from slot 1
      for (int k = 1; k <= `NUM_CHECK; k++) begin
         add_row(RN_SAVE, 0, 0, 0, 3, 60, k, (k == `NUM_CHECK) ? 1 : 0);
      end
      add_row(RN_SAVE, 0, 0, 0, 3, 60, 16, 1);   // Refused on a full ring
      add_row(RN_MAP, 3, 1, 0, 3, 1, 16, 1);
      add_row(RN_RESTORE, 0, 0, 4, 3, 60, 4, 0); // Slot 4 is the fourth oldest
      add_row(RN_MAP, 3, 9, 0, 3, 9, 4, 0);
      add_row(RN_RESTORE, 0, 0, 2, 3, 60, 2, 0);
   endtask

   // ========================================
   // Main sequence
   // ========================================

   initial begin
      row_t        r;
      logic [31:0] rnd;
      int          off;
      arst_n      = 1'b0;
      op          = RN_NOP;
      arch_reg    = '0;
      new_preg    = '0;
      restore_id  = '0;
      lookup_areg = '0;
      model_reset();
      build_table();
      repeat (RESET_CYCLES) @(posedge clka);
      #2;
      arst_n = 1'b1;
      wait_reset_release();

      for (int n = 0; n < rows.size(); n++) begin
         model_step(rows[n]);
         apply_row(rows[n]);
      end

      // Random commands checked against the model every cycle
      rnd = 32'(SEED);
      for (int c = 0; c < RANDOM_CYCLES; c++) begin
         rnd = next_random(rnd);
         case (rnd[2:0])
            3'd0:               r.op = RN_NOP;
            3'd1, 3'd2:         r.op = RN_MAP;
            3'd3, 3'd4, 3'd5:   r.op = RN_SAVE;  // Saves lead so the ring reaches full
            3'd6:               r.op = RN_RESTORE;
            default:            r.op = RN_FREE;
         endcase
         r.arch_reg    = rnd[6:3];
         r.new_preg    = rnd[12:7];
         off           = int'(rnd[16:13]) % (ref_count + 2);  // Mostly live and sometimes dead
         r.restore_id  = chk_id_t'((ref_tail + off) % `NUM_CHECK);
         r.lookup_areg = rnd[20:17];
         model_step(r);
         r.exp_lookup  = ref_map[r.lookup_areg];
         r.exp_count   = chk_cnt_t'(ref_count);
         r.exp_full    = (ref_count == `NUM_CHECK);
         apply_row(r);
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

/* build.f */
+incdir+src
src/rename_pkg.sv
src/rename_op_pkg.sv
src/checkpoint_ram.sv
src/map_table.sv
src/rename_ctrl.sv
src/rename_unit.sv
sim/tb_clock_gen.sv
sim/rename_unit_tb.sv

/* Makefile */
# Verilator flow for the rename map testbench

VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A failing run ends in $fatal and returns a nonzero status
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
